// ==== include/image_buffer_config.svh ====
// Image buffer geometry

`ifndef IMAGE_BUFFER_CONFIG_SVH
`define IMAGE_BUFFER_CONFIG_SVH

// Width of a byte address into the buffer.
// Twelve bits cover 4096 bytes of storage.
`define IB_ADDR_BITS 12

// Number of address bits that select a byte lane within a word.
// The RAM word is 32 bits wide, so four lanes need two bits.
`define IB_LANE_BITS 2

// Width of a word address into the RAM.
// This is the byte address with the lane bits removed, 1024 words.
`define IB_WORD_ADDR_BITS (`IB_ADDR_BITS - `IB_LANE_BITS)

`endif

// ==== verilog/image_buffer_pkg.sv ====
// Image buffer shared types

`default_nettype none

`include "image_buffer_config.svh"

package image_buffer_pkg;

    // One byte written into the buffer at a byte address.
    typedef struct packed {
        logic [`IB_ADDR_BITS-1:0] address;
        logic [7:0]               data;
    } byte_write_t;

    // A full word handed from the packer to the RAM.
    // Lane 0 sits in the low byte of data.
    typedef struct packed {
        logic [`IB_WORD_ADDR_BITS-1:0] word_address;
        logic [31:0]                   data;
    } word_write_t;

    // A byte returned by a read.
    // The collided flag marks a read that lost the RAM port to a commit,
    // in which case data is zero.
    typedef struct packed {
        logic [7:0] data;
        logic       collided;
    } read_result_t;

endpackage

`default_nettype wire

// ==== verilog/write_packer.sv ====
// Byte to word write packer

`timescale 1ns/10ps
`default_nettype none

`include "image_buffer_config.svh"

module write_packer (
    input  logic                          read_clock_in,
    input  logic                          read_reset_n_in,

    input  logic                          write_strobe,
    input  image_buffer_pkg::byte_write_t write_byte,

    output logic                          commit_strobe,
    output image_buffer_pkg::word_write_t commit_word
);

    // Lanes 0 to 2 of the word under construction.
    // Lane 3 never needs storing since its arrival triggers the commit.
    logic [23:0]                   holding;

    logic [`IB_LANE_BITS-1:0]      lane;
    logic [`IB_WORD_ADDR_BITS-1:0] word_address;
    logic                          top_lane_write;

    assign lane         = write_byte.address[`IB_LANE_BITS-1:0];
    assign word_address = write_byte.address[`IB_ADDR_BITS-1:`IB_LANE_BITS];

    // The top lane closes a word.
    assign top_lane_write = write_strobe && (lane == {`IB_LANE_BITS{1'b1}});

    // Holding register and commit strobe.
    always_ff @(posedge read_clock_in) begin
        if (!read_reset_n_in) begin
            holding       <= 24'h000000;
            commit_strobe <= 1'b0;
        end else begin
            commit_strobe <= top_lane_write;

            if (write_strobe) begin
                case (lane)
                    'd0:     holding <= {holding[23:8], write_byte.data};
                    'd1:     holding <= {holding[23:16], write_byte.data, holding[7:0]};
                    'd2:     holding <= {write_byte.data, holding[15:0]};
                    // The holding lanes survive a commit untouched.
                    default: holding <= holding;
                endcase
            end
        end
    end

    // The committed word takes the new top byte together with whatever the
    // holding lanes contain, even if those bytes were aimed at another word.
    always_ff @(posedge read_clock_in) begin
        if (top_lane_write) begin
            commit_word.word_address <= word_address;
            commit_word.data         <= {write_byte.data, holding};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/word_ram.sv ====
// Single port word RAM

`timescale 1ns/10ps
`default_nettype none

`include "image_buffer_config.svh"

module word_ram (
    input  logic                          read_clock_in,
    input  logic                          read_reset_n_in,

    input  logic                          commit_strobe,
    input  image_buffer_pkg::word_write_t commit_word,

    input  logic                          read_strobe,
    input  logic [`IB_ADDR_BITS-1:0]      read_address,

    output logic                          ram_valid,
    output logic [31:0]                   ram_word,
    output logic [`IB_LANE_BITS-1:0]      ram_lane,
    output logic                          ram_collided
);

    localparam int DEPTH = 1 << `IB_WORD_ADDR_BITS;

    logic [31:0]                   mem [0:DEPTH-1];
    logic [`IB_WORD_ADDR_BITS-1:0] address;

    // One port only, so a commit always takes it over a read.
    always_comb begin
        if (commit_strobe) begin
            address = commit_word.word_address;
        end else begin
            address = read_address[`IB_ADDR_BITS-1:`IB_LANE_BITS];
        end
    end

    always_ff @(posedge read_clock_in) begin
        if (commit_strobe) begin
            mem[address] <= commit_word.data;
        end
    end

    // A read that meets a commit is not performed and returns a zero word.
    always_ff @(posedge read_clock_in) begin
        ram_lane <= read_address[`IB_LANE_BITS-1:0];
        if (commit_strobe) begin
            ram_word <= 32'h00000000;
        end else begin
            ram_word <= mem[address];
        end
    end

    always_ff @(posedge read_clock_in) begin
        if (!read_reset_n_in) begin
            ram_valid    <= 1'b0;
            ram_collided <= 1'b0;
        end else begin
            ram_valid    <= read_strobe;
            ram_collided <= read_strobe && commit_strobe;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/read_lane_select.sv ====
// Read byte lane select

`timescale 1ns/10ps
`default_nettype none

`include "image_buffer_config.svh"

module read_lane_select (
    input  logic                           read_clock_in,
    input  logic                           read_reset_n_in,

    input  logic                           ram_valid,
    input  logic [31:0]                    ram_word,
    input  logic [`IB_LANE_BITS-1:0]       ram_lane,
    input  logic                           ram_collided,

    output logic                           read_valid,
    output image_buffer_pkg::read_result_t read_result
);

    logic [7:0] lane_byte;

    // Pick the requested byte out of the RAM word.
    always_comb begin
        case (ram_lane)
            'd0:     lane_byte = ram_word[7:0];
            'd1:     lane_byte = ram_word[15:8];
            'd2:     lane_byte = ram_word[23:16];
            default: lane_byte = ram_word[31:24];
        endcase
    end

    // The result only moves when a read arrives, so it holds the last
    // returned byte between reads.
    always_ff @(posedge read_clock_in) begin
        if (!read_reset_n_in) begin
            read_valid           <= 1'b0;
            read_result.data     <= 8'h00;
            read_result.collided <= 1'b0;
        end else begin
            read_valid <= ram_valid;
            if (ram_valid) begin
                read_result.data     <= lane_byte;
                read_result.collided <= ram_collided;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/image_buffer.sv ====
// Image buffer top level

`timescale 1ns/10ps
`default_nettype none

`include "image_buffer_config.svh"

module image_buffer (
    input  logic                           read_clock_in,
    input  logic                           read_reset_n_in,

    // Byte writes from the capture side.
    input  logic                           write_strobe,
    input  image_buffer_pkg::byte_write_t  write_byte,

    // Byte reads. Their results arrive two cycles after the strobe.
    input  logic                           read_strobe,
    input  logic [`IB_ADDR_BITS-1:0]       read_address,

    output logic                           read_valid,
    output image_buffer_pkg::read_result_t read_result
);

    logic                          commit_strobe;
    image_buffer_pkg::word_write_t commit_word;

    logic                          ram_valid;
    logic [31:0]                   ram_word;
    logic [`IB_LANE_BITS-1:0]      ram_lane;
    logic                          ram_collided;

    write_packer write_packer_i (
        .read_clock_in   (read_clock_in),
        .read_reset_n_in (read_reset_n_in),
        .write_strobe    (write_strobe),
        .write_byte      (write_byte),
        .commit_strobe   (commit_strobe),
        .commit_word     (commit_word)
    );

    word_ram word_ram_i (
        .read_clock_in   (read_clock_in),
        .read_reset_n_in (read_reset_n_in),
        .commit_strobe   (commit_strobe),
        .commit_word     (commit_word),
        .read_strobe     (read_strobe),
        .read_address    (read_address),
        .ram_valid       (ram_valid),
        .ram_word        (ram_word),
        .ram_lane        (ram_lane),
        .ram_collided    (ram_collided)
    );

    read_lane_select read_lane_select_i (
        .read_clock_in   (read_clock_in),
        .read_reset_n_in (read_reset_n_in),
        .ram_valid       (ram_valid),
        .ram_word        (ram_word),
        .ram_lane        (ram_lane),
        .ram_collided    (ram_collided),
        .read_valid      (read_valid),
        .read_result     (read_result)
    );

endmodule

`default_nettype wire

// ==== bench/image_buffer_props.sv ====
// Image buffer timing assertions

`timescale 1ns/10ps
`default_nettype none

`include "image_buffer_config.svh"

module image_buffer_props (
    input  logic                           read_clock_in,
    input  logic                           read_reset_n_in,
    input  logic                           write_strobe,
    input  image_buffer_pkg::byte_write_t  write_byte,
    input  logic                           commit_strobe,
    input  logic                           read_strobe,
    input  logic                           read_valid,
    input  image_buffer_pkg::read_result_t read_result
);

    // Count of failed assertions.
    int unsigned failure_count = 0;

    logic top_lane_write;

    assign top_lane_write = write_strobe &&
        (write_byte.address[`IB_LANE_BITS-1:0] == {`IB_LANE_BITS{1'b1}});

    read_result_follows: assert property (@(posedge read_clock_in) disable iff (!read_reset_n_in)
        read_strobe |-> ##2 read_valid)
    else begin
        failure_count++;
        $error("read_valid missing two cycles after read_strobe");
    end

    read_result_requested: assert property (@(posedge read_clock_in) disable iff (!read_reset_n_in)
        read_valid |-> $past(read_strobe, 2))
    else begin
        failure_count++;
        $error("read_valid without a read_strobe two cycles earlier");
    end

    commit_after_top_lane: assert property (@(posedge read_clock_in) disable iff (!read_reset_n_in)
        commit_strobe |-> $past(top_lane_write))
    else begin
        failure_count++;
        $error("commit_strobe without a lane 3 write one cycle earlier");
    end

    collided_data_zero: assert property (@(posedge read_clock_in)
        (read_valid && read_result.collided) |-> (read_result.data == 8'h00))
    else begin
        failure_count++;
        $error("collided read result carries nonzero data");
    end

    quiet_in_reset: assert property (@(posedge read_clock_in)
        !read_reset_n_in |=> !read_valid)
    else begin
        failure_count++;
        $error("read_valid high during reset");
    end

endmodule

bind image_buffer image_buffer_props image_buffer_props_i (
    .read_clock_in   (read_clock_in),
    .read_reset_n_in (read_reset_n_in),
    .write_strobe    (write_strobe),
    .write_byte      (write_byte),
    .commit_strobe   (commit_strobe),
    .read_strobe     (read_strobe),
    .read_valid      (read_valid),
    .read_result     (read_result)
);

`default_nettype wire

// ==== bench/image_buffer_tb.sv ====
// Image buffer testbench

`timescale 1ns/10ps
`default_nettype none

`include "image_buffer_config.svh"

module image_buffer_tb;

    localparam int CLOCK_PERIOD   = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int LANES          = 1 << `IB_LANE_BITS;
    localparam int DEPTH          = 1 << `IB_WORD_ADDR_BITS;
    localparam int FILL_WORDS     = 16;
    localparam int PACK_ROUNDS    = 8;
    localparam int COLLIDE_ROUNDS = 8;
    localparam int MIX_CYCLES     = 2000;
    localparam int DRAIN_CYCLES   = 4;
    localparam int MARGIN_CYCLES  = 200;

    // Cycles spent by reset and by each test phase including its drain.
    localparam int TEST_CYCLES = RESET_CYCLES + DRAIN_CYCLES
        + FILL_WORDS * 2 * LANES + 1 + DRAIN_CYCLES
        + PACK_ROUNDS * (2 * LANES + 1) + DRAIN_CYCLES
        + COLLIDE_ROUNDS * 3 + DRAIN_CYCLES
        + MIX_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_NS = (TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD;

    typedef struct packed {
        logic [31:0] due_cycle;
        logic [7:0]  data;
        logic        collided;
        logic        check_data;
    } expected_read_t;

    logic                           read_clock_in;
    logic                           read_reset_n_in;
    logic                           write_strobe;
    image_buffer_pkg::byte_write_t  write_byte;
    logic                           read_strobe;
    logic [`IB_ADDR_BITS-1:0]       read_address;
    logic                           read_valid;
    image_buffer_pkg::read_result_t read_result;

    // Reference model state.
    logic [31:0]                   model_mem [0:DEPTH-1];
    logic                          model_committed [0:DEPTH-1];
    logic [23:0]                   model_holding;
    logic                          pending_valid;
    logic [`IB_WORD_ADDR_BITS-1:0] pending_address;
    logic [31:0]                   pending_data;
    expected_read_t                expected_q [$];

    logic [31:0]                   rng_state;
    logic [31:0]                   cycle_count;
    int unsigned                   error_count;
    int unsigned                   assertion_failures;

    image_buffer image_buffer_i (
        .read_clock_in   (read_clock_in),
        .read_reset_n_in (read_reset_n_in),
        .write_strobe    (write_strobe),
        .write_byte      (write_byte),
        .read_strobe     (read_strobe),
        .read_address    (read_address),
        .read_valid      (read_valid),
        .read_result     (read_result)
    );

    initial begin
        read_clock_in = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) read_clock_in = ~read_clock_in;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // The upper LCG bits have the longest period, so fields come from there.
    function logic random_flag();
        rng_state = lcg_next(rng_state);
        return rng_state[31];
    endfunction

    function logic [7:0] random_byte();
        rng_state = lcg_next(rng_state);
        return rng_state[31:24];
    endfunction

    function logic [`IB_WORD_ADDR_BITS-1:0] random_word_address();
        rng_state = lcg_next(rng_state);
        return rng_state[31:32-`IB_WORD_ADDR_BITS];
    endfunction

    function logic [`IB_LANE_BITS-1:0] random_lane();
        rng_state = lcg_next(rng_state);
        return rng_state[31:32-`IB_LANE_BITS];
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s is 0x%h, expected 0x%h at %0t ns",
                     name, actual, expected, $time);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change.
    task automatic check_outputs();
        expected_read_t head;
        if (expected_q.size() > 0 && expected_q[0].due_cycle == cycle_count) begin
            head = expected_q.pop_front();
            check_value("read_valid", 32'(read_valid), 32'd1);
            check_value("read_result.collided", 32'(read_result.collided),
                        32'(head.collided));
            if (head.check_data) begin
                check_value("read_result.data", 32'(read_result.data), 32'(head.data));
            end
        end else begin
            check_value("read_valid", 32'(read_valid), 32'd0);
        end
    endtask

    task automatic run_cycle(
        input logic                     do_write,
        input logic [`IB_ADDR_BITS-1:0] write_address,
        input logic [7:0]               write_data,
        input logic                     do_read,
        input logic [`IB_ADDR_BITS-1:0] address
    );
        expected_read_t                entry;
        logic [`IB_WORD_ADDR_BITS-1:0] word;
        logic [`IB_LANE_BITS-1:0]      lane;

        @(negedge read_clock_in);
        cycle_count++;
        check_outputs();

        write_strobe       = do_write;
        write_byte.address = write_address;
        write_byte.data    = write_data;
        read_strobe        = do_read;
        read_address       = address;

        // A read in the cycle of a commit loses the RAM port.
        if (do_read) begin
            word            = address[`IB_ADDR_BITS-1:`IB_LANE_BITS];
            lane            = address[`IB_LANE_BITS-1:0];
            entry.due_cycle = cycle_count + 32'd2;
            if (pending_valid) begin
                entry.data       = 8'h00;
                entry.collided   = 1'b1;
                entry.check_data = 1'b1;
            end else begin
                entry.data       = model_mem[word][8*lane +: 8];
                entry.collided   = 1'b0;
                entry.check_data = model_committed[word];
            end
            expected_q.push_back(entry);
        end

        // The commit from last cycle's lane 3 write lands at this edge.
        if (pending_valid) begin
            model_mem[pending_address]       = pending_data;
            model_committed[pending_address] = 1'b1;
            pending_valid                    = 1'b0;
        end

        if (do_write) begin
            word = write_address[`IB_ADDR_BITS-1:`IB_LANE_BITS];
            lane = write_address[`IB_LANE_BITS-1:0];
            if (lane == {`IB_LANE_BITS{1'b1}}) begin
                pending_valid   = 1'b1;
                pending_address = word;
                pending_data    = {write_data, model_holding};
            end else begin
                model_holding[8*lane +: 8] = write_data;
            end
        end
    endtask

    task automatic write_cycle(input logic [`IB_ADDR_BITS-1:0] address, input logic [7:0] data);
        run_cycle(1'b1, address, data, 1'b0, '0);
    endtask

    task automatic read_cycle(input logic [`IB_ADDR_BITS-1:0] address);
        run_cycle(1'b0, '0, 8'h00, 1'b1, address);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            run_cycle(1'b0, '0, 8'h00, 1'b0, '0);
        end
    endtask

    // Whole words are written lane by lane, then read back back to back.
    task automatic fill_and_read_back();
        logic [`IB_WORD_ADDR_BITS-1:0] words [FILL_WORDS];
        logic [`IB_LANE_BITS-1:0]      lane;
        for (int w = 0; w < FILL_WORDS; w++) begin
            words[w] = random_word_address();
            for (int l = 0; l < LANES; l++) begin
                lane = l[`IB_LANE_BITS-1:0];
                write_cycle({words[w], lane}, random_byte());
            end
        end
        idle_cycles(1);
        for (int w = 0; w < FILL_WORDS; w++) begin
            for (int l = 0; l < LANES; l++) begin
                lane = l[`IB_LANE_BITS-1:0];
                read_cycle({words[w], lane});
            end
        end
        idle_cycles(DRAIN_CYCLES);
    endtask

    // Low lanes go to one word and the top lane to another.
    task automatic packing_check();
        logic [`IB_WORD_ADDR_BITS-1:0] source;
        logic [`IB_WORD_ADDR_BITS-1:0] target;
        logic [`IB_LANE_BITS-1:0]      lane;
        for (int r = 0; r < PACK_ROUNDS; r++) begin
            source = random_word_address();
            target = random_word_address();
            for (int l = 0; l < LANES - 1; l++) begin
                lane = l[`IB_LANE_BITS-1:0];
                write_cycle({source, lane}, random_byte());
            end
            write_cycle({target, {`IB_LANE_BITS{1'b1}}}, random_byte());
            idle_cycles(1);
            for (int l = 0; l < LANES; l++) begin
                lane = l[`IB_LANE_BITS-1:0];
                read_cycle({target, lane});
            end
        end
        idle_cycles(DRAIN_CYCLES);
    endtask

    // The first read meets the commit and the second one sees it.
    task automatic collision_check();
        logic [`IB_WORD_ADDR_BITS-1:0] target;
        logic [`IB_LANE_BITS-1:0]      lane;
        for (int r = 0; r < COLLIDE_ROUNDS; r++) begin
            target = random_word_address();
            lane   = random_lane();
            write_cycle({target, {`IB_LANE_BITS{1'b1}}}, random_byte());
            read_cycle({target, lane});
            read_cycle({target, lane});
        end
        idle_cycles(DRAIN_CYCLES);
    endtask

    // Traffic is kept to the first 64 words so that reads often hit commits.
    task automatic random_mix();
        logic                     do_write;
        logic                     do_read;
        logic [`IB_ADDR_BITS-1:0] write_address;
        logic [`IB_ADDR_BITS-1:0] address;
        for (int c = 0; c < MIX_CYCLES; c++) begin
            do_write      = random_flag();
            do_read       = random_flag();
            write_address = {{(`IB_ADDR_BITS-8){1'b0}}, random_byte()};
            address       = {{(`IB_ADDR_BITS-8){1'b0}}, random_byte()};
            run_cycle(do_write, write_address, random_byte(), do_read, address);
        end
        idle_cycles(DRAIN_CYCLES);
    endtask

    initial begin
        rng_state       = 32'h3d4a;
        cycle_count     = 32'd0;
        error_count     = 0;
        model_holding   = 24'h000000;
        pending_valid   = 1'b0;
        pending_address = '0;
        pending_data    = 32'h00000000;
        for (int i = 0; i < DEPTH; i++) begin
            model_committed[i] = 1'b0;
        end

        read_reset_n_in = 1'b0;
        write_strobe    = 1'b0;
        write_byte      = '0;
        read_strobe     = 1'b0;
        read_address    = '0;
        repeat (RESET_CYCLES) @(negedge read_clock_in);
        read_reset_n_in = 1'b1;

        // No reads issued yet, so read_valid has to stay low.
        idle_cycles(DRAIN_CYCLES);
        fill_and_read_back();
        packing_check();
        collision_check();
        random_mix();

        if (expected_q.size() != 0) begin
            error_count++;
            $display("Error: %0d reads never returned a result", expected_q.size());
        end

        assertion_failures = image_buffer_i.image_buffer_props_i.failure_count;
        $display("Errors: %0d value, %0d assertion", error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
verilog/image_buffer_pkg.sv
verilog/write_packer.sv
verilog/word_ram.sv
verilog/read_lane_select.sv
verilog/image_buffer.sv
bench/image_buffer_props.sv
bench/image_buffer_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := image_buffer_tb
FILE_LIST  := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := sim passed
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/10ps
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
